//--- src.f
ppu_pkg.sv
ppu_decode.sv
ppu_regs.sv
ppu_line_timer.sv
ppu_stat.sv
ppu_reg_top.sv
tb_clock.sv
tb_ppu_reg.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
	&& verilator --binary --assert -Wno-fatal --top-module tb_ppu_reg -f src.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run.sh: simulation run passed" \
	|| { echo "run.sh: simulation run failed"; exit 1; }

//--- tb_ppu_reg.sv
`timescale 1ns/1ps

module tb_ppu_reg;

	import ppu_pkg::*;

	logic      clk;
	logic      rst_n;
	bus_addr_t addr;
	bus_data_t wdata;
	logic      wr;
	logic      rd;
	bus_data_t rdata;
	logic      stat_irq;
	logic      dma_start;
	bus_data_t dma_page;
	ly_t       ly;
	ppu_mode_e mode;

	bus_data_t shadow [REG_COUNT];
	bus_data_t exp_q [$];
	logic      rd_seen = 1'b0;
	int        cyc = 0;
	int        en_cyc = 0;
	int        errors = 0;
	int        checks = 0;
	int        tests = 0;
	int        seed = 32'h2edf_c007;

	bus_addr_t rw_addrs [8] = '{16'hFF42, 16'hFF43, 16'hFF45, 16'hFF47,
	                            16'hFF48, 16'hFF49, 16'hFF4A, 16'hFF4B};
	// last two points straddle the frame wrap.
	int timer_points [7] = '{12, 90, 300, 952, 65684, 70223, 70229};

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ppu_reg_top u_ppu_reg_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.wdata     (wdata),
		.wr        (wr),
		.rd        (rd),
		.rdata     (rdata),
		.stat_irq  (stat_irq),
		.dma_start (dma_start),
		.dma_page  (dma_page),
		.ly        (ly),
		.mode      (mode)
	);

	function automatic int reg_index(input bus_addr_t a);
		int idx;
		idx = int'(a[7:0]) - int'(REG_BASE[7:0]);
		if (a[15:8] != 8'hFF || idx < 0 || idx >= REG_COUNT)
			return -1;
		return idx;
	endfunction

	// dots counted since the enable write, zero while the LCD is off.
	function automatic int dots_now();
		return shadow[LCDC][LCDC_ENABLE_BIT] ? cyc - en_cyc : 0;
	endfunction

	function automatic ly_t ref_ly(input int t);
		return ly_t'((t / DOTS_PER_LINE) % LINES_PER_FRAME);
	endfunction

	function automatic ppu_mode_e ref_mode(input int t);
		int d;
		d = t % DOTS_PER_LINE;
		if (!shadow[LCDC][LCDC_ENABLE_BIT])
			return HBLANK;
		if (int'(ref_ly(t)) >= VISIBLE_LINES)
			return VBLANK;
		if (d < OAM_DOTS)
			return OAM_SCAN;
		if (d < DRAW_END)
			return DRAW;
		return HBLANK;
	endfunction

	function automatic bus_data_t ref_read(input bus_addr_t a, input int t);
		int idx;
		idx = reg_index(a);
		if (idx < 0)
			return UNMAPPED_DATA;
		if (idx == int'(LY))
			return ref_ly(t);
		if (idx == int'(STAT))
			return {1'b1, shadow[STAT][6:3], ref_ly(t) == shadow[LYC], ref_mode(t)};
		return shadow[idx];
	endfunction

	always @(posedge clk) begin
		cyc     <= cyc + 1;
		rd_seen <= rd;
	end

	// rdata is valid from the edge after the strobe.
	always @(negedge clk) begin
		bus_data_t want;
		if (rd_seen) begin
			want = exp_q.pop_front();
			checks++;
			assert (rdata == want)
				else begin
					$display("Mismatch rdata: got %h, expected %h", rdata, want);
					errors++;
				end
		end
	end

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic check_val(input string sig, input logic [15:0] got,
			input logic [15:0] want);
		checks++;
		assert (got == want)
			else begin
				$display("Mismatch %s: got %h, expected %h", sig, got, want);
				errors++;
			end
	endtask

	task automatic bus_write(input bus_addr_t a, input bus_data_t d);
		int idx;
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		@(posedge clk);
		#1;
		wr  = 1'b0;
		idx = reg_index(a);
		if (idx >= 0 && idx != int'(LY)) begin
			if (idx == int'(LCDC) && d[LCDC_ENABLE_BIT] && !shadow[LCDC][LCDC_ENABLE_BIT])
				en_cyc = cyc;
			shadow[idx] = (idx == int'(STAT)) ? (d & 8'h78) : d;
		end
	endtask

	task automatic bus_read(input bus_addr_t a);
		addr = a;
		rd   = 1'b1;
		exp_q.push_back(ref_read(a, dots_now()));
		@(posedge clk);
		#1;
		rd = 1'b0;
	endtask

	task automatic wait_dots(input int target);
		int n;
		n = 0;
		while (dots_now() < target) begin
			@(posedge clk);
			#1;
			n++;
			if (n > DOTS_PER_LINE * LINES_PER_FRAME)
				abort_run("timer point never reached");
		end
	endtask

	// samples stat_irq until a few dots into the target line.
	task automatic watch_irq(input ly_t line, output int pulses, output ly_t at_ly);
		int n;
		int tail;
		n      = 0;
		tail   = -1;
		pulses = 0;
		at_ly  = '0;
		while (tail != 0) begin
			@(posedge clk);
			#1;
			if (stat_irq) begin
				pulses++;
				at_ly = ly;
			end
			if (tail > 0)
				tail--;
			else if (tail < 0 && ly == line)
				tail = 4;
			n++;
			if (n > DOTS_PER_LINE * LINES_PER_FRAME)
				abort_run("target line never reached");
		end
	endtask

	task automatic report_test(input int num, input string name, input int base);
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 8)
				abort_run("read data never returned");
		end
		if (errors == base)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d error(s)", num, name, errors - base);
		tests++;
	endtask

	initial begin
		bus_data_t d;
		ly_t       pulse_ly;
		int        pulses;
		int        base;
		int        n;
		addr  = '0;
		wdata = '0;
		wr    = 1'b0;
		rd    = 1'b0;
		foreach (shadow[i])
			shadow[i] = '0;
		n = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			n++;
			if (n > 20)
				abort_run("reset never released");
		end
		@(posedge clk);
		#1;

		base = errors;
		check_val("rdata", rdata, UNMAPPED_DATA);
		check_val("stat_irq", stat_irq, 1'b0);
		check_val("ly", ly, 8'h00);
		for (int r = 0; r < 2; r++) begin
			foreach (rw_addrs[i])
				bus_write(rw_addrs[i], bus_data_t'($random(seed)));
			foreach (rw_addrs[i])
				bus_read(rw_addrs[i]);
		end
		bus_write(16'hFF4B, bus_data_t'($random(seed)));
		bus_read(16'hFF4B);
		report_test(1, "register read-back", base);

		base = errors;
		bus_write(16'hFF44, 8'h5A);
		bus_read(16'hFF44);
		bus_read(16'hFF4C);
		bus_read(16'hFF3F);
		bus_read(16'h0040);
		report_test(2, "read-only LY and unmapped reads", base);

		base = errors;
		bus_write(16'hFF41, 8'hFF);
		bus_read(16'hFF41);
		bus_write(16'hFF45, 8'h00);
		bus_read(16'hFF41);
		bus_write(16'hFF41, 8'h00);
		bus_read(16'hFF41);
		report_test(3, "STAT masking", base);

		base = errors;
		bus_write(16'hFF40, 8'h91);
		bus_read(16'hFF44);
		foreach (timer_points[i]) begin
			wait_dots(timer_points[i]);
			check_val("ly", ly, ref_ly(dots_now()));
			check_val("mode", mode, ref_mode(dots_now()));
			bus_read(16'hFF44);
			bus_read(16'hFF41);
		end
		report_test(4, "line timer", base);

		base = errors;
		bus_write(16'hFF45, 8'd10);
		bus_write(16'hFF41, 8'h40);
		watch_irq(8'd10, pulses, pulse_ly);
		bus_read(16'hFF41);
		checks++;
		assert (pulses == 1 && pulse_ly == 8'd10)
			else begin
				$display("stat_irq pulsed %0d times (last on line %0d), expected once on line 10",
					pulses, pulse_ly);
				errors++;
			end
		bus_write(16'hFF41, 8'h00);
		bus_write(16'hFF45, 8'd20);
		watch_irq(8'd20, pulses, pulse_ly);
		bus_read(16'hFF41);
		checks++;
		assert (pulses == 0)
			else begin
				$display("stat_irq pulsed %0d times with its source disabled", pulses);
				errors++;
			end
		report_test(5, "LY=LYC interrupt", base);

		base = errors;
		d = bus_data_t'($random(seed));
		check_val("dma_start", dma_start, 1'b0);
		bus_write(16'hFF46, d);
		check_val("dma_start", dma_start, 1'b1);
		check_val("dma_page", dma_page, d);
		@(posedge clk);
		#1;
		check_val("dma_start", dma_start, 1'b0);
		bus_read(16'hFF46);
		report_test(6, "DMA start pulse", base);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held over four rising edges.
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- ppu_reg_top.sv
`timescale 1ns/1ps

module ppu_reg_top (
	input  logic               clk,
	input  logic               rst_n,
	input  ppu_pkg::bus_addr_t addr,
	input  ppu_pkg::bus_data_t wdata,
	input  logic               wr,
	input  logic               rd,
	output ppu_pkg::bus_data_t rdata,
	output logic               stat_irq,
	output logic               dma_start,
	output ppu_pkg::bus_data_t dma_page,
	output ppu_pkg::ly_t       ly,
	output ppu_pkg::ppu_mode_e mode
);

	import ppu_pkg::*;

	reg_sel_t   sel;
	logic       hit;
	bus_data_t  lcdc;
	bus_data_t  scy;
	bus_data_t  scx;
	bus_data_t  lyc;
	bus_data_t  bgp;
	bus_data_t  obp0;
	bus_data_t  obp1;
	bus_data_t  wy;
	bus_data_t  wx;
	logic [3:0] stat_en;

	ppu_decode u_decode (
		.addr (addr),
		.sel  (sel),
		.hit  (hit)
	);

	ppu_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.wdata     (wdata),
		.wr        (wr),
		.sel       (sel),
		.lcdc      (lcdc),
		.scy       (scy),
		.scx       (scx),
		.lyc       (lyc),
		.bgp       (bgp),
		.obp0      (obp0),
		.obp1      (obp1),
		.wy        (wy),
		.wx        (wx),
		.dma_page  (dma_page),
		.stat_en   (stat_en),
		.dma_start (dma_start)
	);

	// dot position feeds pixel logic outside this block.
	ppu_line_timer u_line_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.lcd_on (lcdc[LCDC_ENABLE_BIT]),
		.ly     (ly),
		.dot    (),
		.mode   (mode)
	);

	ppu_stat u_stat (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd       (rd),
		.sel      (sel),
		.hit      (hit),
		.ly       (ly),
		.mode     (mode),
		.lyc      (lyc),
		.stat_en  (stat_en),
		.lcdc     (lcdc),
		.scy      (scy),
		.scx      (scx),
		.dma_page (dma_page),
		.bgp      (bgp),
		.obp0     (obp0),
		.obp1     (obp1),
		.wy       (wy),
		.wx       (wx),
		.rdata    (rdata),
		.stat_irq (stat_irq)
	);

endmodule

//--- ppu_stat.sv
`timescale 1ns/1ps

module ppu_stat (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rd,
	input  ppu_pkg::reg_sel_t  sel,
	input  logic               hit,
	input  ppu_pkg::ly_t       ly,
	input  ppu_pkg::ppu_mode_e mode,
	input  ppu_pkg::bus_data_t lyc,
	input  logic [3:0]         stat_en,
	input  ppu_pkg::bus_data_t lcdc,
	input  ppu_pkg::bus_data_t scy,
	input  ppu_pkg::bus_data_t scx,
	input  ppu_pkg::bus_data_t dma_page,
	input  ppu_pkg::bus_data_t bgp,
	input  ppu_pkg::bus_data_t obp0,
	input  ppu_pkg::bus_data_t obp1,
	input  ppu_pkg::bus_data_t wy,
	input  ppu_pkg::bus_data_t wx,
	output ppu_pkg::bus_data_t rdata,
	output logic               stat_irq
);

	import ppu_pkg::*;

	logic      coincidence;
	bus_data_t stat_byte;
	bus_data_t rd_mux;
	logic      irq_cond;
	logic      irq_cond_q;

	assign coincidence = (ly == lyc);

	// bit 7 is unused and reads high.
	assign stat_byte = {1'b1, stat_en, coincidence, mode};

	always_comb begin
		rd_mux = UNMAPPED_DATA;
		if (hit) begin
			unique case (1'b1)
				sel[LCDC]: rd_mux = lcdc;
				sel[STAT]: rd_mux = stat_byte;
				sel[SCY]:  rd_mux = scy;
				sel[SCX]:  rd_mux = scx;
				sel[LY]:   rd_mux = ly;
				sel[LYC]:  rd_mux = lyc;
				sel[DMA]:  rd_mux = dma_page;
				sel[BGP]:  rd_mux = bgp;
				sel[OBP0]: rd_mux = obp0;
				sel[OBP1]: rd_mux = obp1;
				sel[WY]:   rd_mux = wy;
				sel[WX]:   rd_mux = wx;
			endcase
		end
	end

	// sources in STAT bit order 3 to 6.
	assign irq_cond = (stat_en[0] && (mode == HBLANK)) ||
	                  (stat_en[1] && (mode == VBLANK)) ||
	                  (stat_en[2] && (mode == OAM_SCAN)) ||
	                  (stat_en[3] && coincidence);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata      <= UNMAPPED_DATA;
			irq_cond_q <= 1'b0;
			stat_irq   <= 1'b0;
		end else begin
			if (rd)
				rdata <= rd_mux;
			irq_cond_q <= irq_cond;
			stat_irq   <= irq_cond && !irq_cond_q;
		end
	end

endmodule

//--- ppu_line_timer.sv
`timescale 1ns/1ps

module ppu_line_timer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               lcd_on,
	output ppu_pkg::ly_t       ly,
	output ppu_pkg::dot_t      dot,
	output ppu_pkg::ppu_mode_e mode
);

	import ppu_pkg::*;

	logic line_end;
	logic frame_end;
	logic in_vblank;

	assign line_end  = (dot == dot_t'(DOTS_PER_LINE - 1));
	assign frame_end = (ly == ly_t'(LINES_PER_FRAME - 1));
	assign in_vblank = (ly >= ly_t'(VISIBLE_LINES));

	// counters sit at zero while the LCD is off.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dot <= '0;
			ly  <= '0;
		end else if (!lcd_on) begin
			dot <= '0;
			ly  <= '0;
		end else if (line_end) begin
			dot <= '0;
			ly  <= frame_end ? '0 : ly + 1'b1;
		end else begin
			dot <= dot + 1'b1;
		end
	end

	always_comb begin
		if (!lcd_on)
			mode = HBLANK;
		else if (in_vblank)
			mode = VBLANK;
		else if (dot < dot_t'(OAM_DOTS))
			mode = OAM_SCAN;
		else if (dot < dot_t'(DRAW_END))
			mode = DRAW;
		else
			mode = HBLANK;
	end

	a_ly_range: assert property (@(posedge clk) disable iff (!rst_n)
		ly < ly_t'(LINES_PER_FRAME))
		else $error("ppu_line_timer: ly out of range %0d", ly);

	a_dot_range: assert property (@(posedge clk) disable iff (!rst_n)
		dot < dot_t'(DOTS_PER_LINE))
		else $error("ppu_line_timer: dot out of range %0d", dot);

endmodule

//--- ppu_regs.sv
`timescale 1ns/1ps

module ppu_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  ppu_pkg::bus_data_t wdata,
	input  logic               wr,
	input  ppu_pkg::reg_sel_t  sel,
	output ppu_pkg::bus_data_t lcdc,
	output ppu_pkg::bus_data_t scy,
	output ppu_pkg::bus_data_t scx,
	output ppu_pkg::bus_data_t lyc,
	output ppu_pkg::bus_data_t bgp,
	output ppu_pkg::bus_data_t obp0,
	output ppu_pkg::bus_data_t obp1,
	output ppu_pkg::bus_data_t wy,
	output ppu_pkg::bus_data_t wx,
	output ppu_pkg::bus_data_t dma_page,
	output logic [3:0]         stat_en,
	output logic               dma_start
);

	import ppu_pkg::*;

	reg_sel_t we;

	assign we = wr ? sel : '0;

	// LY has no storage, a write to it is dropped.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lcdc      <= '0;
			stat_en   <= '0;
			scy       <= '0;
			scx       <= '0;
			lyc       <= '0;
			dma_page  <= '0;
			bgp       <= '0;
			obp0      <= '0;
			obp1      <= '0;
			wy        <= '0;
			wx        <= '0;
			dma_start <= 1'b0;
		end else begin
			if (we[LCDC])
				lcdc <= wdata;
			// only the interrupt enables are writable.
			if (we[STAT])
				stat_en <= wdata[6:3];
			if (we[SCY])
				scy <= wdata;
			if (we[SCX])
				scx <= wdata;
			if (we[LYC])
				lyc <= wdata;
			if (we[DMA])
				dma_page <= wdata;
			if (we[BGP])
				bgp <= wdata;
			if (we[OBP0])
				obp0 <= wdata;
			if (we[OBP1])
				obp1 <= wdata;
			if (we[WY])
				wy <= wdata;
			if (we[WX])
				wx <= wdata;
			dma_start <= we[DMA];
		end
	end

	// back-to-back DMA writes mean a restart while a transfer runs.
	a_dma_single: assert property (@(posedge clk) disable iff (!rst_n)
		dma_start |=> !dma_start)
		else $error("ppu_regs: dma_start held for two cycles");

endmodule

//--- ppu_decode.sv
`timescale 1ns/1ps

module ppu_decode (
	input  ppu_pkg::bus_addr_t addr,
	output ppu_pkg::reg_sel_t  sel,
	output logic               hit
);

	import ppu_pkg::*;

	logic      page_ff;
	bus_data_t offset;

	// high byte must be FF.
	assign page_ff = (addr[15:8] == REG_BASE[15:8]);

	// offset from FF40, wraps for 3F and below.
	assign offset = addr[7:0] - REG_BASE[7:0];

	always_comb begin
		sel = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			if (page_ff && (offset == 8'(i))) begin
				sel[i] = 1'b1;
			end
		end
	end

	assign hit = |sel;

endmodule

//--- ppu_pkg.sv
package ppu_pkg;

	// bus side widths.
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0]  bus_data_t;

	// one bit per display register, bit n is FF40+n.
	typedef logic [11:0] reg_sel_t;

	// scanline timer widths.
	typedef logic [7:0] ly_t;
	typedef logic [8:0] dot_t;

	typedef enum logic [3:0] {
		LCDC = 4'd0,
		STAT = 4'd1,
		SCY  = 4'd2,
		SCX  = 4'd3,
		LY   = 4'd4,
		LYC  = 4'd5,
		DMA  = 4'd6,
		BGP  = 4'd7,
		OBP0 = 4'd8,
		OBP1 = 4'd9,
		WY   = 4'd10,
		WX   = 4'd11
	} reg_idx_e;

	// encoding matches STAT bits 1:0.
	typedef enum logic [1:0] {
		HBLANK   = 2'd0,
		VBLANK   = 2'd1,
		OAM_SCAN = 2'd2,
		DRAW     = 2'd3
	} ppu_mode_e;

	localparam bus_addr_t REG_BASE  = 16'hFF40;
	localparam int        REG_COUNT = 12;

	localparam int DOTS_PER_LINE   = 456;
	localparam int LINES_PER_FRAME = 154;
	localparam int VISIBLE_LINES   = 144;
	localparam int OAM_DOTS        = 80;
	localparam int DRAW_END        = 252;

	localparam bus_data_t UNMAPPED_DATA   = 8'hFF;
	localparam int        LCDC_ENABLE_BIT = 7;

endpackage
